// File: hdl/io_map_pkg.sv
/*
 * I/O bus word, word-address and LED types
 * word addresses and status bit positions of the I/O page
 */
package io_map_pkg;

    typedef logic [31:0] bus_word_t;   // data word of the I/O bus
    typedef logic [3:0]  io_addr_t;    // word address inside the I/O page
    typedef logic [7:0]  led_t;        // LED pattern

    // read / write meaning of each word
    localparam io_addr_t IO_ADDR_MS        = 4'd0;  // millisecond count / --
    localparam io_addr_t IO_ADDR_LED       = 4'd1;  // -- / LED pattern
    localparam io_addr_t IO_ADDR_UART_DATA = 4'd2;  // rx data / tx data (start)
    localparam io_addr_t IO_ADDR_UART_STAT = 4'd3;  // status / dequeue

    // status word layout
    localparam int IO_STAT_RX_AVAIL = 0;  // receive FIFO not empty
    localparam int IO_STAT_TX_READY = 1;  // transmitter idle

endpackage

// File: hdl/serial_pkg.sv
/*
 * UART payload type, frame bit counts and FSM state enums
 */
package serial_pkg;

    typedef logic [7:0] uart_byte_t;  // serial payload

    localparam int UART_DATA_BITS = 8;
    localparam int UART_BIT_IDX_W = $clog2(UART_DATA_BITS);  // data bit index width

    // literal names carry a prefix, both enums share this scope
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

// File: hdl/periph_if.sv
/*
 * UART transmit and receive FIFO signals between the register block
 * and the serial peripherals
 */
interface periph_if;

    logic       tx_start;    // one-cycle start strobe
    logic [7:0] tx_data;     // byte to send, valid with tx_start
    logic       tx_ready;    // transmitter idle
    logic       fifo_pop;    // dequeue strobe
    logic [7:0] fifo_data;   // head of the receive FIFO
    logic       fifo_empty;

    modport regs (
        output tx_start, tx_data, fifo_pop,
        input  tx_ready, fifo_data, fifo_empty
    );

    modport periph (
        input  tx_start, tx_data, fifo_pop,
        output tx_ready, fifo_data, fifo_empty
    );

endinterface

// File: hdl/io_regs.sv
/*
 * I/O register block: address decode, read mux, LED register,
 * receive data register, transmit-start and dequeue strobes
 */
module io_regs import io_map_pkg::*, serial_pkg::*; (
    input  logic      clk_cpu,
    input  logic      rst_n,
    input  logic      io_rd_i,
    input  logic      io_wr_i,
    input  io_addr_t  io_addr_i,
    input  bus_word_t io_wdata_i,
    input  bus_word_t ms_count_i,
    output bus_word_t io_rdata_o,
    output led_t      led_o,
    periph_if.regs    periph
);

    logic       wr_led;
    logic       wr_tx;
    logic       wr_deq;
    uart_byte_t rx_data;   // last dequeued byte
    bus_word_t  status;

    assign wr_led = io_wr_i && (io_addr_i == IO_ADDR_LED);
    assign wr_tx  = io_wr_i && (io_addr_i == IO_ADDR_UART_DATA);
    assign wr_deq = io_wr_i && (io_addr_i == IO_ADDR_UART_STAT);

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            led_o           <= '0;
            periph.tx_start <= 1'b0;
            periph.fifo_pop <= 1'b0;
            rx_data         <= '0;
        end else begin
            periph.tx_start <= wr_tx;
            periph.fifo_pop <= wr_deq && !periph.fifo_empty;  // pop only real data
            if (wr_led)
                led_o <= io_wdata_i[7:0];
            if (periph.fifo_pop)
                rx_data <= periph.fifo_data;  // head before the pointer moves
        end
    end

    // tx byte travels with the start strobe
    always_ff @(posedge clk_cpu) begin
        if (wr_tx)
            periph.tx_data <= io_wdata_i[7:0];
    end

    always_comb begin
        status                   = '0;
        status[IO_STAT_TX_READY] = periph.tx_ready;
        status[IO_STAT_RX_AVAIL] = !periph.fifo_empty;
    end

    // reads have no side effects, LED and unmapped words read 0
    always_comb begin
        case (io_addr_i)
            IO_ADDR_MS:        io_rdata_o = ms_count_i;
            IO_ADDR_UART_DATA: io_rdata_o = {24'd0, rx_data};
            IO_ADDR_UART_STAT: io_rdata_o = status;
            default:           io_rdata_o = '0;
        endcase
    end

    // single-master bus, never both strobes in one cycle
    a_rd_wr_excl: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        !(io_rd_i && io_wr_i));

endmodule

// File: hdl/ms_timer.sv
/*
 * millisecond timer: cycle prescaler and 32-bit millisecond counter
 */
module ms_timer import io_map_pkg::*; #(
    parameter int FREQ_HZ = 25_000_000
) (
    input  logic      clk_cpu,
    input  logic      rst_n,
    output bus_word_t ms_count_o
);

    localparam int CYCLES_PER_MS = FREQ_HZ / 1000;
    localparam int PRE_W         = $clog2(CYCLES_PER_MS);

    logic [PRE_W-1:0] prescale;
    logic             ms_tick;

    assign ms_tick = (prescale == PRE_W'(CYCLES_PER_MS - 1));

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            prescale   <= '0;
            ms_count_o <= '0;
        end else begin
            prescale <= ms_tick ? '0 : prescale + 1'b1;  // wraps once per ms
            if (ms_tick)
                ms_count_o <= ms_count_o + 32'd1;
        end
    end

endmodule

// File: hdl/uart_tx.sv
/*
 * UART transmitter: start bit, 8 data bits LSB first, one stop bit
 */
module uart_tx import serial_pkg::*; #(
    parameter int FREQ_HZ   = 25_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic     clk_cpu,
    input  logic     rst_n,
    periph_if.periph periph,
    output logic     tx_o
);

    localparam int CLKS_PER_BIT = FREQ_HZ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    tx_state_t                 state;
    logic [CNT_W-1:0]          clk_cnt;
    logic [UART_BIT_IDX_W-1:0] bit_idx;
    uart_byte_t                shift;
    logic                      bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    // not ready in the strobe cycle either, the frame is already committed
    assign periph.tx_ready = (state == TX_IDLE) && !periph.tx_start;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx_o    <= 1'b1;
        end else begin
            clk_cnt <= (state == TX_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    if (periph.tx_start) begin
                        state <= TX_START;
                        tx_o  <= 1'b0;  // start bit
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        tx_o    <= shift[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == UART_BIT_IDX_W'(UART_DATA_BITS - 1)) begin
                            state <= TX_STOP;
                            tx_o  <= 1'b1;  // stop bit
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx_o    <= shift[0];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end)
                        state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (state == TX_IDLE && periph.tx_start)
            shift <= periph.tx_data;
        else if (bit_end && (state == TX_START || state == TX_DATA))
            shift <= shift >> 1;  // next bit into position 0
    end

    // software polls tx ready, a start during a frame would be lost
    a_no_start_busy: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        periph.tx_start |-> state == TX_IDLE);

endmodule

// File: hdl/uart_rx.sv
/*
 * UART receiver: two-flop input synchronizer, mid-bit sampling,
 * one-cycle push of each frame with a valid stop bit
 */
module uart_rx import serial_pkg::*; #(
    parameter int FREQ_HZ   = 25_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic       clk_cpu,
    input  logic       rst_n,
    input  logic       rx_i,
    output logic       push_o,
    output uart_byte_t push_data_o
);

    localparam int CLKS_PER_BIT = FREQ_HZ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    rx_state_t                 state;
    logic                      rx_meta;
    logic                      rx_sync;
    logic [CNT_W-1:0]          clk_cnt;
    logic [UART_BIT_IDX_W-1:0] bit_idx;
    uart_byte_t                shift;
    logic                      bit_end;
    logic                      half_end;

    assign bit_end     = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign half_end    = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign push_data_o = shift;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;  // line idles high
            rx_sync <= 1'b1;
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            push_o  <= 1'b0;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            push_o  <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync)
                        state <= RX_START;
                end
                RX_START: begin
                    if (half_end) begin  // centre of the start bit
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // glitch goes back
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        if (bit_idx == UART_BIT_IDX_W'(UART_DATA_BITS - 1))
                            state <= RX_STOP;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        push_o <= rx_sync;  // framing error drops the byte
                        state  <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (state == RX_DATA && bit_end)
            shift <= {rx_sync, shift[UART_DATA_BITS-1:1]};  // LSB arrives first
    end

endmodule

// File: hdl/rx_fifo.sv
/*
 * receive FIFO: circular buffer of received bytes, full pushes dropped
 */
module rx_fifo import serial_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk_cpu,
    input  logic       rst_n,
    input  logic       push_i,
    input  uart_byte_t push_data_i,
    periph_if.periph   periph
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    uart_byte_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push           = push_i && (count != CNT_W'(FIFO_DEPTH));
    assign do_pop            = periph.fifo_pop && (count != '0);
    assign periph.fifo_empty = (count == '0);
    assign periph.fifo_data  = mem[rd_ptr];

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // power-of-two depth wraps
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (do_push)
            mem[wr_ptr] <= push_data_i;
    end

    a_no_pop_empty: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        !(periph.fifo_pop && periph.fifo_empty));

endmodule

// File: hdl/io_top.sv
/*
 * memory-mapped I/O block: register block beside the millisecond timer,
 * UART transmitter, UART receiver and receive FIFO
 */
module io_top import io_map_pkg::*, serial_pkg::*; #(
    parameter int FREQ_HZ    = 25_000_000,
    parameter int BAUD_RATE  = 115_200,
    parameter int FIFO_DEPTH = 16          // power of two
) (
    input  logic      clk_cpu,
    input  logic      rst_n,
    input  logic      io_rd_i,
    input  logic      io_wr_i,
    input  io_addr_t  io_addr_i,
    input  bus_word_t io_wdata_i,
    output bus_word_t io_rdata_o,
    output led_t      led_o,
    input  logic      rx_i,
    output logic      tx_o
);

    periph_if   periph ();
    bus_word_t  ms_count;
    logic       rx_push;
    uart_byte_t rx_push_data;

    io_regs i_regs (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .io_rd_i    (io_rd_i),
        .io_wr_i    (io_wr_i),
        .io_addr_i  (io_addr_i),
        .io_wdata_i (io_wdata_i),
        .ms_count_i (ms_count),
        .io_rdata_o (io_rdata_o),
        .led_o      (led_o),
        .periph     (periph)
    );

    ms_timer #(.FREQ_HZ(FREQ_HZ)) i_ms_timer (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .ms_count_o (ms_count)
    );

    uart_tx #(.FREQ_HZ(FREQ_HZ), .BAUD_RATE(BAUD_RATE)) i_uart_tx (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n),
        .periph  (periph),
        .tx_o    (tx_o)
    );

    uart_rx #(.FREQ_HZ(FREQ_HZ), .BAUD_RATE(BAUD_RATE)) i_uart_rx (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .rx_i        (rx_i),
        .push_o      (rx_push),
        .push_data_o (rx_push_data)
    );

    rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_rx_fifo (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .push_i      (rx_push),
        .push_data_i (rx_push_data),
        .periph      (periph)
    );

endmodule

// File: tests/tb_clock.sv
/*
 * testbench clock and reset: 40 ns clock, reset low for the first cycles
 */
module tb_clock #(
    parameter int HALF_PERIOD  = 20,  // ns
    parameter int RESET_CYCLES = 3
) (
    output logic clk_cpu,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_cpu = 1'b0;
        forever #(HALF_PERIOD) clk_cpu = ~clk_cpu;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_cpu);
        @(negedge clk_cpu);
        rst_n = 1'b1;  // released on a falling edge
    end

endmodule

// File: tests/tb_io_top.sv
/*
 * testbench of the I/O block: bus tasks, LFSR stimulus, serial line model,
 * reset, LED, millisecond counter, transmit, receive and overflow tests
 */
module tb_io_top import io_map_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FREQ_HZ       = 250_000;
    localparam int BAUD_RATE     = 25_000;
    localparam int FIFO_DEPTH    = 16;
    localparam int CLKS_PER_BIT  = FREQ_HZ / BAUD_RATE;  // 10
    localparam int CYCLES_PER_MS = FREQ_HZ / 1000;       // 250
    // reset, LED, ms counter, transmit, receive, overflow
    localparam int TEST_CYCLES = 40 + 20 * 5 + 6 * 1030 + 8 * 110 + 6 * 135
                                 + (FIFO_DEPTH + 3) * 130 + FIFO_DEPTH * 10;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic        clk_cpu;
    logic        rst_n;
    logic        io_rd_i;
    logic        io_wr_i;
    io_addr_t    io_addr_i;
    bus_word_t   io_wdata_i;
    bus_word_t   io_rdata_o;
    led_t        led_o;
    logic        rx_i;
    logic        tx_o;
    logic [31:0] lfsr = 32'ha5ae_85aa;
    int unsigned edge_cnt = 0;   // rising edges with reset released
    int unsigned cycle_cnt = 0;
    int          errors = 0;
    int          test_err_base = 0;
    int          tests = 0;

    tb_clock i_clock (.clk_cpu(clk_cpu), .rst_n(rst_n));

    io_top #(.FREQ_HZ(FREQ_HZ), .BAUD_RATE(BAUD_RATE), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .io_rd_i    (io_rd_i),
        .io_wr_i    (io_wr_i),
        .io_addr_i  (io_addr_i),
        .io_wdata_i (io_wdata_i),
        .io_rdata_o (io_rdata_o),
        .led_o      (led_o),
        .rx_i       (rx_i),
        .tx_o       (tx_o)
    );

    // Galois taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s, %0d errors", name,
                 (errors == test_err_base) ? "passed" : "failed", errors - test_err_base);
        test_err_base = errors;
        tests++;
    endtask

    task automatic write_reg(input io_addr_t addr, input bus_word_t data);
        @(negedge clk_cpu);
        io_rd_i    = 1'b0;
        io_wr_i    = 1'b1;
        io_addr_i  = addr;
        io_wdata_i = data;
    endtask

    // combinational read data sampled just after the drive edge
    task automatic read_reg(input io_addr_t addr, output bus_word_t data);
        @(negedge clk_cpu);
        io_wr_i   = 1'b0;
        io_rd_i   = 1'b1;
        io_addr_i = addr;
        #1;
        data = io_rdata_o;
    endtask

    task automatic idle_bus(input int cycles);
        repeat (cycles) begin
            @(negedge clk_cpu);
            io_rd_i = 1'b0;
            io_wr_i = 1'b0;
        end
    endtask

    // start bit, 8 data bits LSB first, stop bit, then idle line
    task automatic send_frame(input logic [7:0] data, input int gap);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk_cpu);
            rx_i = bits[i];
            repeat (CLKS_PER_BIT - 1) @(negedge clk_cpu);
        end
        repeat (gap) @(negedge clk_cpu);
    endtask

    task automatic pop_byte(output bus_word_t data);
        write_reg(IO_ADDR_UART_STAT, '0);  // dequeue
        idle_bus(2);
        read_reg(IO_ADDR_UART_DATA, data);
    endtask

    always @(posedge clk_cpu) begin
        if (rst_n)
            edge_cnt <= edge_cnt + 1;
    end

    always @(posedge clk_cpu) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        bus_word_t  rd;
        bus_word_t  st;
        bus_word_t  wd;
        logic [7:0] b;
        logic [9:0] frame_exp;
        logic [7:0] exp_q[$];
        int         pops;
        io_rd_i    = 1'b0;
        io_wr_i    = 1'b0;
        io_addr_i  = '0;
        io_wdata_i = '0;
        rx_i       = 1'b1;  // idle line
        wait (rst_n === 1'b1);

        idle_bus(1);
        if (led_o !== 8'h00) report_mismatch("led_o", led_o, 0);
        if (tx_o !== 1'b1) report_mismatch("tx_o", tx_o, 1);
        read_reg(IO_ADDR_UART_STAT, rd);
        if (rd !== 32'd2) report_mismatch("status", rd, 2);
        read_reg(IO_ADDR_UART_DATA, rd);
        if (rd !== 32'd0) report_mismatch("rx data", rd, 0);
        for (int a = 1; a < 16; a++) begin
            if (a != 2 && a != 3) begin
                read_reg(io_addr_t'(a), rd);
                if (rd !== 32'd0) report_mismatch($sformatf("io_rdata_o @%0d", a), rd, 0);
            end
        end
        end_test("reset");

        repeat (20) begin
            wd = rand_bits(32);
            write_reg(IO_ADDR_LED, wd);
            idle_bus(1);
            if (led_o !== wd[7:0]) report_mismatch("led_o", led_o, wd[7:0]);
            read_reg(IO_ADDR_LED, rd);
            if (rd !== 32'd0) report_mismatch("io_rdata_o", rd, 0);
        end
        end_test("led");

        repeat (6) begin
            idle_bus(1 + int'(rand_bits(10)));
            read_reg(IO_ADDR_MS, rd);
            if (rd !== edge_cnt / CYCLES_PER_MS)
                report_mismatch("ms count", rd, edge_cnt / CYCLES_PER_MS);
        end
        end_test("ms_timer");

        repeat (8) begin
            wd = rand_bits(32);
            st = '0;
            while (st[1] !== 1'b1)
                read_reg(IO_ADDR_UART_STAT, st);  // wait for tx ready
            write_reg(IO_ADDR_UART_DATA, wd);
            idle_bus(5);  // first sample near the centre of the start bit
            frame_exp = {1'b1, wd[7:0], 1'b0};
            for (int i = 0; i < 10; i++) begin
                read_reg(IO_ADDR_UART_STAT, st);
                if (tx_o !== frame_exp[i])
                    report_mismatch($sformatf("tx_o bit %0d", i), tx_o, frame_exp[i]);
                if (st[1] !== 1'b0) report_mismatch("status tx ready", st[1], 0);
                idle_bus(CLKS_PER_BIT - 1);
            end
        end
        end_test("transmit");

        for (int f = 0; f < 6; f++) begin
            wd = rand_bits(8);
            b = wd[7:0];
            exp_q.push_back(b);
            send_frame(b, 4 + int'(rand_bits(4)));
        end
        read_reg(IO_ADDR_UART_STAT, st);
        if (st[0] !== 1'b1) report_mismatch("status rx avail", st[0], 1);
        while (exp_q.size() > 0) begin
            pop_byte(rd);
            b = exp_q.pop_front();
            if (rd !== {24'd0, b}) report_mismatch("rx data", rd, b);
        end
        read_reg(IO_ADDR_UART_STAT, st);
        if (st[0] !== 1'b0) report_mismatch("status rx avail", st[0], 0);
        end_test("receive");

        for (int f = 0; f < FIFO_DEPTH + 3; f++) begin
            wd = rand_bits(8);
            b = wd[7:0];
            if (exp_q.size() < FIFO_DEPTH)
                exp_q.push_back(b);  // full FIFO drops the rest
            send_frame(b, 4 + int'(rand_bits(4)));
        end
        pops = 0;
        read_reg(IO_ADDR_UART_STAT, st);
        while (st[0] === 1'b1) begin
            pop_byte(rd);
            pops++;
            if (exp_q.size() > 0) begin
                b = exp_q.pop_front();
                if (rd !== {24'd0, b}) report_mismatch("rx data", rd, b);
            end
            read_reg(IO_ADDR_UART_STAT, st);
        end
        if (pops != FIFO_DEPTH) begin
            $display("** Error at %0t ns: FIFO gave back %0d bytes after overflow, not %0d",
                     $time, pops, FIFO_DEPTH);
            errors++;
        end
        end_test("overflow");

        $display("tests: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: flist.f
hdl/io_map_pkg.sv
hdl/serial_pkg.sv
hdl/periph_if.sv
hdl/io_regs.sv
hdl/ms_timer.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/rx_fifo.sv
hdl/io_top.sv
tests/tb_clock.sv
tests/tb_io_top.sv

// File: run.sh
#!/bin/sh
# build the I/O block testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_io_top \
    -f flist.f -o sim_io_top > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_io_top > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && exit 1 || exit 0
